/* logic/pmp_macros.svh */
// pmp sizing for a 32-bit core with 8 entries and 4-byte granularity; values are fixed here
`ifndef PMP_MACROS_SVH
`define PMP_MACROS_SVH

// number of pmp entries held by the unit
`define PMP_ENTRIES 8

// address and data width of the core
`define PMP_XLEN 32

// width of an entry index, log2 of PMP_ENTRIES
`define PMP_IDX_W 3

// permission bits in the configuration byte
`define PMP_CFG_R 0
`define PMP_CFG_W 1
`define PMP_CFG_X 2

// address-match mode field, bits 4:3
`define PMP_CFG_A_LO 3
`define PMP_CFG_A_HI 4

// lock bit, also applies the entry to machine mode
`define PMP_CFG_L 7

`endif

/* logic/pmp_cfg_pkg.sv */
// stored pmp entry types; pmpaddr holds a word address whose bits 31:30 must be zero to match
`default_nettype none

package pmp_cfg_pkg;

  `include "pmp_macros.svh"

  // A field encoding of pmpcfg
  typedef enum logic [1:0] {
    OFF   = 2'd0,
    TOR   = 2'd1,
    NA4   = 2'd2,
    NAPOT = 2'd3
  } pmp_amode_e;

  // one configuration byte: L, 2'b0, A, X, W, R
  typedef logic [7:0] pmpcfg_t;

  // one address register, physical address bits 33:2
  typedef logic [`PMP_XLEN-1:0] pmpaddr_t;

  // pull the match mode out of a configuration byte
  function automatic pmp_amode_e cfg_amode(input pmpcfg_t cfg);
    return pmp_amode_e'(cfg[`PMP_CFG_A_HI:`PMP_CFG_A_LO]);
  endfunction

  // locked entries ignore writes and bind machine mode
  function automatic logic cfg_locked(input pmpcfg_t cfg);
    return cfg[`PMP_CFG_L];
  endfunction

endpackage

`default_nettype wire

/* logic/pmp_access_pkg.sv */
// checked access types; hypervisor mode and MPRV are not modeled, encoding 3 of the kind is unused
`default_nettype none

package pmp_access_pkg;

  // kind of the access being checked
  // selects the R, W or X bit of the matching entry
  typedef enum logic [1:0] {
    ACC_READ  = 2'd0,
    ACC_WRITE = 2'd1,
    ACC_EXEC  = 2'd2
  } pmp_access_e;

  // privilege mode of the requester
  // value 2 is reserved in the privileged spec
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } pmp_priv_e;

endpackage

`default_nettype wire

/* logic/pmp_matcher.sv */
// combinational match of one entry; addresses are word addresses and granularity is 4 bytes
`timescale 1ns/1ps
`default_nettype none

module pmp_matcher (
  // access address, already shifted to a word address
  input  pmp_cfg_pkg::pmpaddr_t word_addr,
  // configuration byte of this entry
  input  pmp_cfg_pkg::pmpcfg_t  cfg,
  // pmpaddr of this entry
  input  pmp_cfg_pkg::pmpaddr_t cfg_addr,
  // pmpaddr of the entry below, lower bound for tor
  input  pmp_cfg_pkg::pmpaddr_t cfg_addr_before,
  output logic                  match
);

  import pmp_cfg_pkg::*;

  pmpaddr_t addr_same;
  pmpaddr_t napot_mask;
  pmpaddr_t napot_hit;

  // bitwise equality of access and entry address
  assign addr_same  = word_addr ~^ cfg_addr;
  // trailing ones of pmpaddr plus the zero just above them
  assign napot_mask = cfg_addr ^ (cfg_addr + 1'b1);
  // masked bits always agree
  assign napot_hit  = addr_same | napot_mask;

  always_comb begin
    match = 1'b0;
    case (cfg_amode(cfg))
      // single word region
      NA4: begin
        match = (word_addr == cfg_addr);
      end
      // [before, own) range, empty when bounds are inverted or equal
      TOR: begin
        if (cfg_addr_before >= cfg_addr) begin
          match = 1'b0;
        end else begin
          match = (word_addr >= cfg_addr_before) && (word_addr < cfg_addr);
        end
      end
      // all unmasked bits must agree
      NAPOT: begin
        match = &napot_hit;
      end
      // disabled entry
      OFF: begin
        match = 1'b0;
      end
      default: begin
        match = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* logic/pmp_csr_file.sv */
// pmpcfg/pmpaddr registers behind a four-phase port; csr_req must stay high until csr_ack rises
`timescale 1ns/1ps
`default_nettype none
`include "pmp_macros.svh"

module pmp_csr_file (
  input  logic                                      clk,
  input  logic                                      rst_n,
  // configuration port
  input  logic                                      csr_req,
  input  logic                                      csr_we,
  // 0 selects pmpcfg, 1 selects pmpaddr
  input  logic                                      csr_sel,
  input  logic [`PMP_IDX_W-1:0]                     csr_idx,
  input  logic [`PMP_XLEN-1:0]                      csr_wdata,
  output logic                                      csr_ack,
  output logic [`PMP_XLEN-1:0]                      csr_rdata,
  // live entry state towards the checker
  output pmp_cfg_pkg::pmpcfg_t  [`PMP_ENTRIES-1:0] entry_cfg,
  output pmp_cfg_pkg::pmpaddr_t [`PMP_ENTRIES-1:0] entry_addr
);

  import pmp_cfg_pkg::*;

  localparam int LAST_IDX = `PMP_ENTRIES - 1;

  logic [`PMP_IDX_W-1:0] next_idx;
  logic                  sel_locked;
  logic                  next_tor_locked;
  logic                  cfg_wr_ok;
  logic                  addr_wr_ok;
  logic                  accept;
  logic [`PMP_XLEN-1:0]  rd_value;

  // new request, not yet acknowledged
  assign accept = csr_req && !csr_ack;

  // entry just above the selected one, only valid below the last index
  assign next_idx = csr_idx + 1'b1;

  assign sel_locked = cfg_locked(entry_cfg[csr_idx]);

  // a locked tor entry guards the lower bound held by its neighbour
  assign next_tor_locked = (int'(csr_idx) != LAST_IDX) &&
                           cfg_locked(entry_cfg[next_idx]) &&
                           (cfg_amode(entry_cfg[next_idx]) == TOR);

  assign cfg_wr_ok  = csr_we && !csr_sel && !sel_locked;
  assign addr_wr_ok = csr_we && csr_sel && !sel_locked && !next_tor_locked;

  // value held once the write is resolved
  // a dropped write returns the old contents
  always_comb begin
    if (csr_sel) begin
      rd_value = addr_wr_ok ? csr_wdata : entry_addr[csr_idx];
    end else if (cfg_wr_ok) begin
      rd_value = {{(`PMP_XLEN-8){1'b0}}, csr_wdata[7:0]};
    end else begin
      rd_value = {{(`PMP_XLEN-8){1'b0}}, entry_cfg[csr_idx]};
    end
  end

  // entry registers and handshake
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      csr_ack    <= 1'b0;
      entry_cfg  <= '0;
      entry_addr <= '0;
    end else if (accept) begin
      csr_ack <= 1'b1;
      if (cfg_wr_ok) begin
        entry_cfg[csr_idx] <= csr_wdata[7:0];
      end
      if (addr_wr_ok) begin
        entry_addr[csr_idx] <= csr_wdata;
      end
    end else if (!csr_req) begin
      // phase 4, release ack once req is gone
      csr_ack <= 1'b0;
    end
  end

  // read data captured with ack
  always_ff @(posedge clk) begin
    if (accept) begin
      csr_rdata <= rd_value;
    end
  end

  // ack only answers a request seen on the previous edge
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(csr_ack) |-> $past(csr_req));

  // read data holds for the whole ack phase
  assert property (@(posedge clk) disable iff (!rst_n)
    (csr_ack && $past(csr_ack)) |-> $stable(csr_rdata));

endmodule

`default_nettype wire

/* logic/pmp_checker.sv */
// one access check per four-phase handshake; 34-bit addresses and MPRV are not supported
`timescale 1ns/1ps
`default_nettype none
`include "pmp_macros.svh"

module pmp_checker (
  input  logic                                      clk,
  input  logic                                      rst_n,
  // check port
  input  logic                                      chk_req,
  // byte address of the access
  input  logic [`PMP_XLEN-1:0]                      chk_addr,
  input  pmp_access_pkg::pmp_access_e               chk_kind,
  input  pmp_access_pkg::pmp_priv_e                 chk_priv,
  // entry state from the register file
  input  pmp_cfg_pkg::pmpcfg_t  [`PMP_ENTRIES-1:0] entry_cfg,
  input  pmp_cfg_pkg::pmpaddr_t [`PMP_ENTRIES-1:0] entry_addr,
  output logic                                      chk_ack,
  output logic                                      chk_allow
);

  import pmp_cfg_pkg::*;
  import pmp_access_pkg::*;

  pmpaddr_t                   word_addr;
  pmpaddr_t [`PMP_ENTRIES-1:0] prev_addr;
  logic [`PMP_ENTRIES-1:0]     match;
  logic                        hit;
  pmpcfg_t                     hit_cfg;
  logic                        perm;
  logic                        allow_d;

  // drop the byte offset, top bits zero
  assign word_addr = {2'b00, chk_addr[`PMP_XLEN-1:2]};

  // one matcher per entry
  // entry 0 starts its tor range at address zero
  for (genvar g = 0; g < `PMP_ENTRIES; g++) begin : gen_match
    if (g == 0) begin : gen_first
      assign prev_addr[g] = '0;
    end else begin : gen_rest
      assign prev_addr[g] = entry_addr[g-1];
    end

    pmp_matcher pmp_matcher_inst (
      .word_addr       (word_addr),
      .cfg             (entry_cfg[g]),
      .cfg_addr        (entry_addr[g]),
      .cfg_addr_before (prev_addr[g]),
      .match           (match[g])
    );
  end

  // lowest-indexed match wins
  always_comb begin
    hit     = 1'b0;
    hit_cfg = '0;
    for (int i = 0; i < `PMP_ENTRIES; i++) begin
      if (match[i] && !hit) begin
        hit     = 1'b1;
        hit_cfg = entry_cfg[i];
      end
    end
  end

  // permission bit for the access kind, unknown kinds denied
  always_comb begin
    case (chk_kind)
      ACC_READ:  perm = hit_cfg[`PMP_CFG_R];
      ACC_WRITE: perm = hit_cfg[`PMP_CFG_W];
      ACC_EXEC:  perm = hit_cfg[`PMP_CFG_X];
      default:   perm = 1'b0;
    endcase
  end

  always_comb begin
    if (!hit) begin
      // no match: only machine mode passes
      allow_d = (chk_priv == PRIV_M);
    end else if ((chk_priv == PRIV_M) && !cfg_locked(hit_cfg)) begin
      // unlocked entries do not bind machine mode
      allow_d = 1'b1;
    end else begin
      allow_d = perm;
    end
  end

  // result registered with ack
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      chk_ack   <= 1'b0;
      chk_allow <= 1'b0;
    end else if (chk_req && !chk_ack) begin
      chk_ack   <= 1'b1;
      chk_allow <= allow_d;
    end else if (!chk_req) begin
      chk_ack <= 1'b0;
    end
  end

  // ack only follows a request sampled on the edge before
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(chk_ack) |-> $past(chk_req));

  // decision holds while the requester reads it
  assert property (@(posedge clk) disable iff (!rst_n)
    (chk_ack && $past(chk_ack)) |-> $stable(chk_allow));

endmodule

`default_nettype wire

/* logic/pmp_unit.sv */
// pmp top with separate config and check ports; a config write and a check on one edge see old state
`timescale 1ns/1ps
`default_nettype none
`include "pmp_macros.svh"

module pmp_unit (
  input  logic                        clk,
  input  logic                        rst_n,
  // configuration port
  input  logic                        csr_req,
  input  logic                        csr_we,
  input  logic                        csr_sel,
  input  logic [`PMP_IDX_W-1:0]       csr_idx,
  input  logic [`PMP_XLEN-1:0]        csr_wdata,
  output logic                        csr_ack,
  output logic [`PMP_XLEN-1:0]        csr_rdata,
  // check port
  input  logic                        chk_req,
  input  logic [`PMP_XLEN-1:0]        chk_addr,
  input  pmp_access_pkg::pmp_access_e chk_kind,
  input  pmp_access_pkg::pmp_priv_e   chk_priv,
  output logic                        chk_ack,
  output logic                        chk_allow
);

  import pmp_cfg_pkg::*;

  // entry state shared by both halves
  pmpcfg_t  [`PMP_ENTRIES-1:0] entry_cfg;
  pmpaddr_t [`PMP_ENTRIES-1:0] entry_addr;

  pmp_csr_file pmp_csr_file_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .csr_req    (csr_req),
    .csr_we     (csr_we),
    .csr_sel    (csr_sel),
    .csr_idx    (csr_idx),
    .csr_wdata  (csr_wdata),
    .csr_ack    (csr_ack),
    .csr_rdata  (csr_rdata),
    .entry_cfg  (entry_cfg),
    .entry_addr (entry_addr)
  );

  pmp_checker pmp_checker_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .chk_req    (chk_req),
    .chk_addr   (chk_addr),
    .chk_kind   (chk_kind),
    .chk_priv   (chk_priv),
    .entry_cfg  (entry_cfg),
    .entry_addr (entry_addr),
    .chk_ack    (chk_ack),
    .chk_allow  (chk_allow)
  );

endmodule

`default_nettype wire

/* test/pmp_tb.sv */
// directed pmp testbench; locked entries only clear by reset, so each test starts from a reset
`timescale 1ns/1ps
`default_nettype none
`include "pmp_macros.svh"

module pmp_tb;

  import pmp_cfg_pkg::*;
  import pmp_access_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int ACK_LIMIT  = 10;
  // rough count of all handshakes, random part included
  localparam int NUM_TXNS   = 340;
  localparam int WATCHDOG_CYCLES = NUM_TXNS * 10 + 200;

  logic                  clk;
  logic                  rst_n;
  logic                  csr_req;
  logic                  csr_we;
  logic                  csr_sel;
  logic [`PMP_IDX_W-1:0] csr_idx;
  logic [`PMP_XLEN-1:0]  csr_wdata;
  logic                  csr_ack;
  logic [`PMP_XLEN-1:0]  csr_rdata;
  logic                  chk_req;
  logic [`PMP_XLEN-1:0]  chk_addr;
  pmp_access_e           chk_kind;
  pmp_priv_e             chk_priv;
  logic                  chk_ack;
  logic                  chk_allow;

  // shadow copy of the entry registers
  logic [7:0]            sh_cfg  [`PMP_ENTRIES];
  logic [`PMP_XLEN-1:0]  sh_addr [`PMP_ENTRIES];
  int                    errors;
  int                    checks;

  pmp_unit pmp_unit_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .csr_req   (csr_req),
    .csr_we    (csr_we),
    .csr_sel   (csr_sel),
    .csr_idx   (csr_idx),
    .csr_wdata (csr_wdata),
    .csr_ack   (csr_ack),
    .csr_rdata (csr_rdata),
    .chk_req   (chk_req),
    .chk_addr  (chk_addr),
    .chk_kind  (chk_kind),
    .chk_priv  (chk_priv),
    .chk_ack   (chk_ack),
    .chk_allow (chk_allow)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch in %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    end
  endtask

  // polls ack a few ns after each edge, counts cycles up to the limit
  task automatic wait_for_ack(input bit on_chk, input bit level, input string name);
    int n;
    n = 0;
    while (((on_chk ? chk_ack : csr_ack) !== level) && n < ACK_LIMIT) begin
      @(posedge clk);
      #2;
      n++;
    end
    if ((on_chk ? chk_ack : csr_ack) !== level) begin
      errors++;
      $display("%s: %s ack never reached %0d within %0d cycles", name,
               on_chk ? "check" : "csr", level, ACK_LIMIT);
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int i = 0; i < `PMP_ENTRIES; i++) begin
      sh_cfg[i]  = '0;
      sh_addr[i] = '0;
    end
  endtask

  task automatic csr_xfer(input logic we, input logic sel, input int idx,
                          input logic [31:0] wdata, input string name,
                          output logic [31:0] rdata);
    csr_we    = we;
    csr_sel   = sel;
    csr_idx   = idx[`PMP_IDX_W-1:0];
    csr_wdata = wdata;
    csr_req   = 1'b1;
    wait_for_ack(1'b0, 1'b1, name);
    rdata   = csr_rdata;
    csr_req = 1'b0;
    wait_for_ack(1'b0, 1'b0, name);
  endtask

  // applies the lock rules to the shadow and returns the value held afterwards
  function automatic logic [31:0] shadow_write(input logic sel, input int idx,
                                               input logic [31:0] wdata);
    logic locked;
    logic guard;
    locked = sh_cfg[idx][7];
    guard  = (idx < `PMP_ENTRIES - 1) && sh_cfg[idx+1][7] && (sh_cfg[idx+1][4:3] == 2'd1);
    if (!sel) begin
      if (!locked) sh_cfg[idx] = wdata[7:0];
      return {24'd0, sh_cfg[idx]};
    end
    if (!locked && !guard) sh_addr[idx] = wdata;
    return sh_addr[idx];
  endfunction

  task automatic csr_write(input string name, input logic sel, input int idx,
                           input logic [31:0] wdata);
    logic [31:0] exp;
    logic [31:0] rd;
    exp = shadow_write(sel, idx, wdata);
    csr_xfer(1'b1, sel, idx, wdata, name, rd);
    compare(name, exp, rd);
  endtask

  task automatic csr_read(input string name, input logic sel, input int idx,
                          input logic [31:0] exp);
    logic [31:0] rd;
    csr_xfer(1'b0, sel, idx, '0, name, rd);
    compare(name, exp, rd);
  endtask

  task automatic check_access(input string name, input logic [31:0] addr,
                              input pmp_access_e kind, input pmp_priv_e priv, input logic exp);
    chk_addr = addr;
    chk_kind = kind;
    chk_priv = priv;
    chk_req  = 1'b1;
    wait_for_ack(1'b1, 1'b1, name);
    compare(name, {31'd0, exp}, {31'd0, chk_allow});
    chk_req = 1'b0;
    wait_for_ack(1'b1, 1'b0, name);
  endtask

  // expected decision from the shadow entries
  function automatic logic ref_allow(input logic [31:0] addr, input pmp_access_e kind,
                                     input pmp_priv_e priv);
    logic [31:0] word;
    logic [31:0] lo;
    logic [31:0] mask;
    logic        hit;
    int          k;
    word = {2'b00, addr[31:2]};
    for (int i = 0; i < `PMP_ENTRIES; i++) begin
      lo  = (i == 0) ? 32'd0 : sh_addr[i-1];
      hit = 1'b0;
      case (sh_cfg[i][4:3])
        2'd1: hit = (lo < sh_addr[i]) && (word >= lo) && (word < sh_addr[i]);
        2'd2: hit = (word == sh_addr[i]);
        2'd3: begin
          k = 0;
          while (k < 32 && sh_addr[i][k]) k++;
          // region of 2^(k+1) words
          mask = 32'hFFFF_FFFF << (k + 1);
          hit  = ((word & mask) == (sh_addr[i] & mask));
        end
        default: hit = 1'b0;
      endcase
      if (hit) begin
        if (priv == PRIV_M && !sh_cfg[i][7]) return 1'b1;
        return sh_cfg[i][int'(kind)];
      end
    end
    return (priv == PRIV_M);
  endfunction

  initial begin
    pmp_priv_e   priv;
    pmp_access_e kind;
    logic [31:0] addr;
    int          r;
    rst_n = 1'b0;
    csr_req = 1'b0;
    csr_we = 1'b0;
    csr_sel = 1'b0;
    csr_idx = '0;
    csr_wdata = '0;
    chk_req = 1'b0;
    chk_addr = '0;
    chk_kind = ACC_READ;
    chk_priv = PRIV_M;
    errors = 0;
    checks = 0;
    void'($urandom(63262));
    @(posedge clk);
    #2;

    // reset defaults
    apply_reset();
    for (int i = 0; i < `PMP_ENTRIES; i++) begin
      csr_read("reset_cfg", 1'b0, i, 32'd0);
      csr_read("reset_addr", 1'b1, i, 32'd0);
    end
    check_access("reset_user_read", 32'h1000, ACC_READ, PRIV_U, 1'b0);
    check_access("reset_mach_write", 32'h1000, ACC_WRITE, PRIV_M, 1'b1);

    // register access and locks
    apply_reset();
    csr_write("reg_cfg", 1'b0, 1, 32'hFFFF_FF07);
    csr_read("reg_cfg_rd", 1'b0, 1, 32'h07);
    csr_write("reg_addr", 1'b1, 1, 32'h0000_1234);
    csr_read("reg_addr_rd", 1'b1, 1, 32'h0000_1234);
    csr_write("lock_cfg", 1'b0, 2, 32'h91);
    csr_write("locked_cfg_wr", 1'b0, 2, 32'h07);
    csr_read("locked_cfg_rd", 1'b0, 2, 32'h91);
    csr_write("locked_addr_wr", 1'b1, 2, 32'h55);
    csr_read("locked_addr_rd", 1'b1, 2, 32'h0);
    csr_write("tor_lock_cfg", 1'b0, 4, 32'h89);
    csr_write("below_locked_tor", 1'b1, 3, 32'h100);
    csr_read("below_locked_tor_rd", 1'b1, 3, 32'h0);
    csr_write("tor_open_cfg", 1'b0, 6, 32'h09);
    csr_write("below_open_tor", 1'b1, 5, 32'h100);
    csr_read("below_open_tor_rd", 1'b1, 5, 32'h100);

    // na4 at 0x100 read only, napot 64 bytes at 0x200 write and exec
    apply_reset();
    csr_write("na4_addr", 1'b1, 0, 32'h40);
    csr_write("na4_cfg", 1'b0, 0, 32'h11);
    csr_write("napot_addr", 1'b1, 1, 32'h87);
    csr_write("napot_cfg", 1'b0, 1, 32'h1E);
    check_access("na4_read_in", 32'h100, ACC_READ, PRIV_U, 1'b1);
    check_access("na4_write_in", 32'h100, ACC_WRITE, PRIV_U, 1'b0);
    check_access("na4_exec_in", 32'h103, ACC_EXEC, PRIV_U, 1'b0);
    check_access("na4_read_above", 32'h104, ACC_READ, PRIV_U, 1'b0);
    check_access("na4_read_below", 32'h0FC, ACC_READ, PRIV_U, 1'b0);
    check_access("napot_write_base", 32'h200, ACC_WRITE, PRIV_U, 1'b1);
    check_access("napot_exec_top", 32'h23C, ACC_EXEC, PRIV_U, 1'b1);
    check_access("napot_read_in", 32'h220, ACC_READ, PRIV_U, 1'b0);
    check_access("napot_write_above", 32'h240, ACC_WRITE, PRIV_U, 1'b0);
    check_access("napot_write_below", 32'h1FC, ACC_WRITE, PRIV_U, 1'b0);

    // tor ranges, entry 1 is an off entry holding the lower bound of entry 2
    apply_reset();
    csr_write("tor0_addr", 1'b1, 0, 32'h40);
    csr_write("tor0_cfg", 1'b0, 0, 32'h09);
    csr_write("bound_addr", 1'b1, 1, 32'h80);
    csr_write("tor2_addr", 1'b1, 2, 32'h100);
    csr_write("tor2_cfg", 1'b0, 2, 32'h0B);
    csr_write("inv_addr", 1'b1, 3, 32'h50);
    csr_write("inv_cfg", 1'b0, 3, 32'h0F);
    csr_write("eq_addr", 1'b1, 4, 32'h50);
    csr_write("eq_cfg", 1'b0, 4, 32'h0F);
    check_access("tor0_from_zero", 32'h0, ACC_READ, PRIV_U, 1'b1);
    check_access("tor0_last_word", 32'h0FC, ACC_READ, PRIV_U, 1'b1);
    check_access("tor0_upper", 32'h100, ACC_READ, PRIV_U, 1'b0);
    check_access("tor2_lower", 32'h200, ACC_WRITE, PRIV_U, 1'b1);
    check_access("tor2_below_upper", 32'h3FC, ACC_WRITE, PRIV_U, 1'b1);
    check_access("tor2_upper", 32'h400, ACC_WRITE, PRIV_U, 1'b0);
    check_access("tor_inverted", 32'h100, ACC_READ, PRIV_U, 1'b0);
    check_access("tor_equal", 32'h140, ACC_READ, PRIV_U, 1'b0);

    // overlapping entries and machine mode
    apply_reset();
    csr_write("prio_na4_addr", 1'b1, 0, 32'h40);
    csr_write("prio_na4_cfg", 1'b0, 0, 32'h11);
    csr_write("prio_napot_addr", 1'b1, 1, 32'h47);
    csr_write("prio_napot_cfg", 1'b0, 1, 32'h1B);
    check_access("prio_low_wins", 32'h100, ACC_WRITE, PRIV_U, 1'b0);
    check_access("prio_next_entry", 32'h104, ACC_WRITE, PRIV_S, 1'b1);
    check_access("mach_unlocked", 32'h100, ACC_WRITE, PRIV_M, 1'b1);
    csr_write("prio_lock", 1'b0, 0, 32'h91);
    check_access("mach_locked_write", 32'h100, ACC_WRITE, PRIV_M, 1'b0);
    check_access("mach_locked_read", 32'h100, ACC_READ, PRIV_M, 1'b1);

    // random unlocked configuration against the reference function
    apply_reset();
    for (int i = 0; i < `PMP_ENTRIES; i++) begin
      csr_write("rand_addr", 1'b1, i, $urandom & 32'h3FF);
      csr_write("rand_cfg", 1'b0, i, $urandom & 32'h1F);
    end
    for (int n = 0; n < 200; n++) begin
      addr = $urandom & 32'h0FFF;
      kind = pmp_access_e'($urandom % 3);
      r    = $urandom % 3;
      priv = (r == 2) ? PRIV_M : pmp_priv_e'(r);
      check_access("random", addr, kind, priv, ref_allow(addr, kind, priv));
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/pmp_cfg_pkg.sv
logic/pmp_access_pkg.sv
logic/pmp_matcher.sv
logic/pmp_csr_file.sv
logic/pmp_checker.sv
logic/pmp_unit.sv
test/pmp_tb.sv

/* Bender.yml */
package:
  name: pmp_unit

sources:
  - include_dirs:
      - logic
    files:
      - logic/pmp_cfg_pkg.sv
      - logic/pmp_access_pkg.sv
      - logic/pmp_matcher.sv
      - logic/pmp_csr_file.sv
      - logic/pmp_checker.sv
      - logic/pmp_unit.sv

  - target: test
    include_dirs:
      - logic
    files:
      - test/pmp_tb.sv
